//--- hdl/sync_pkg.sv
package sync_pkg;

    // bits per I or Q component of a complex sample.
    localparam int SAMPLE_DW = 8;

    // a complex sample carries I in the upper byte and Q in the lower byte.
    typedef logic [2*SAMPLE_DW-1:0] iq_t;

    // one signed I or Q component.
    typedef logic signed [SAMPLE_DW-1:0] comp_t;

    // correlator length in samples.
    localparam int PSS_LEN = 16;

    // in the local PSS a set bit is a +1 tap and a clear bit is a -1 tap.
    // bit 0 belongs to the oldest sample of the window.
    localparam logic [PSS_LEN-1:0] PSS_SEQ = 16'b1011_0011_1010_0001;

    // a signed I or Q correlation sum is wide enough for PSS_LEN full-scale samples.
    localparam int CORR_DW = 13;
    typedef logic signed [CORR_DW-1:0] corr_t;

    // the correlation magnitude is |sum I| + |sum Q|.
    localparam int METRIC_DW = 14;
    typedef logic [METRIC_DW-1:0] metric_t;

endpackage

//--- hdl/frame_pkg.sv
package frame_pkg;

    // useful samples per OFDM symbol and symbols per SS/PBCH block.
    localparam int SYM_LEN = 32;
    localparam int SSB_SYMBOLS = 4;

    typedef logic [3:0] cp_len_t;
    typedef logic [1:0] sym_idx_t;
    typedef logic [$clog2(SYM_LEN)-1:0] samp_cnt_t;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_CP,
        FS_SYMBOL
    } frame_state_t;

    // configuration register map.
    typedef logic [1:0] cfg_addr_t;
    localparam cfg_addr_t CFG_THRESH = 2'd0;
    localparam cfg_addr_t CFG_CP_LEN = 2'd1;
    localparam cfg_addr_t CFG_SSB_COUNT = 2'd2;

    localparam int RST_THRESH = 200;
    localparam cp_len_t RST_CP_LEN = 4'd4;

endpackage

//--- hdl/sample_if.sv
`timescale 1ns/10ps

interface sample_if;

    sync_pkg::iq_t        data;
    logic                 valid;
    sync_pkg::metric_t    metric;
    logic                 peak;
    // the framing flags only carry meaning on the framer output.
    logic                 symbol_start;
    logic                 last;
    frame_pkg::sym_idx_t  symbol_idx;

    modport src (
        output data, valid, metric, peak, symbol_start, last, symbol_idx
    );

    modport dst (
        input data, valid, metric, peak, symbol_start, last, symbol_idx
    );

endinterface

//--- hdl/pss_correlator.sv
`timescale 1ns/10ps

module pss_correlator (
    input  logic          clk_i,
    input  logic          rst_i,
    input  sync_pkg::iq_t s_data_i,
    input  logic          s_valid_i,
    sample_if.src         out_bus
);

    sync_pkg::iq_t                        window [sync_pkg::PSS_LEN];
    sync_pkg::iq_t                        win_next [sync_pkg::PSS_LEN];
    logic [$clog2(sync_pkg::PSS_LEN)-1:0] fill;
    logic                                 full;
    sync_pkg::comp_t                      comp_i;
    sync_pkg::comp_t                      comp_q;
    sync_pkg::corr_t                      sum_i;
    sync_pkg::corr_t                      sum_q;
    logic [sync_pkg::CORR_DW-1:0]         abs_i;
    logic [sync_pkg::CORR_DW-1:0]         abs_q;
    sync_pkg::metric_t                    metric_next;

    // the window as it stands once the incoming sample has been shifted in.
    always_comb begin
        for (int k = 0; k < sync_pkg::PSS_LEN - 1; k++) begin
            win_next[k] = window[k + 1];
        end
        win_next[sync_pkg::PSS_LEN - 1] = s_data_i;
    end

    always_comb begin
        sum_i = '0;
        sum_q = '0;
        comp_i = '0;
        comp_q = '0;
        for (int k = 0; k < sync_pkg::PSS_LEN; k++) begin
            comp_i = win_next[k][2*sync_pkg::SAMPLE_DW-1:sync_pkg::SAMPLE_DW];
            comp_q = win_next[k][sync_pkg::SAMPLE_DW-1:0];
            if (sync_pkg::PSS_SEQ[k]) begin
                sum_i = sum_i + comp_i;
                sum_q = sum_q + comp_q;
            end else begin
                sum_i = sum_i - comp_i;
                sum_q = sum_q - comp_q;
            end
        end
        abs_i = sum_i[sync_pkg::CORR_DW-1] ? -sum_i : sum_i;
        abs_q = sum_q[sync_pkg::CORR_DW-1] ? -sum_q : sum_q;
        metric_next = sync_pkg::metric_t'(abs_i) + sync_pkg::metric_t'(abs_q);
    end

    // the window is full on the PSS_LEN-th sample after reset.
    assign full = (fill == ($clog2(sync_pkg::PSS_LEN))'(sync_pkg::PSS_LEN - 1));

    always_ff @(posedge clk_i) begin
        if (s_valid_i) begin
            window <= win_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fill <= '0;
            out_bus.valid <= 1'b0;
            out_bus.metric <= '0;
        end else begin
            out_bus.valid <= s_valid_i;
            if (s_valid_i) begin
                out_bus.metric <= full ? metric_next : '0;
                if (!full) begin
                    fill <= fill + 1'b1;
                end
            end
        end
    end

    // the newest window entry is the sample the metric belongs to.
    assign out_bus.data = window[sync_pkg::PSS_LEN - 1];
    assign out_bus.peak = 1'b0;
    assign out_bus.symbol_start = 1'b0;
    assign out_bus.last = 1'b0;
    assign out_bus.symbol_idx = '0;

endmodule

//--- hdl/peak_detector.sv
`timescale 1ns/10ps

module peak_detector (
    input  logic              clk_i,
    input  logic              rst_i,
    input  sync_pkg::metric_t thresh_i,
    sample_if.dst             in_bus,
    sample_if.src             out_bus
);

    sync_pkg::iq_t     hold_data;
    sync_pkg::metric_t hold_metric;
    logic              hold_vld;
    sync_pkg::metric_t prev_metric;
    logic              is_peak;

    // the held sample is a peak when it clears the threshold, rises above
    // the sample before it and is not exceeded by the sample after it.
    assign is_peak = (hold_metric >= thresh_i)
                  && (hold_metric > prev_metric)
                  && (hold_metric >= in_bus.metric);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hold_vld <= 1'b0;
            hold_metric <= '0;
            prev_metric <= '0;
            out_bus.valid <= 1'b0;
            out_bus.peak <= 1'b0;
        end else begin
            out_bus.valid <= 1'b0;
            out_bus.peak <= 1'b0;
            if (in_bus.valid) begin
                if (hold_vld) begin
                    out_bus.valid <= 1'b1;
                    out_bus.peak <= is_peak;
                    prev_metric <= hold_metric;
                end
                hold_vld <= 1'b1;
                hold_metric <= in_bus.metric;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_bus.valid) begin
            hold_data <= in_bus.data;
            out_bus.data <= hold_data;
        end
    end

    assign out_bus.metric = '0;
    assign out_bus.symbol_start = 1'b0;
    assign out_bus.last = 1'b0;
    assign out_bus.symbol_idx = '0;

endmodule

//--- hdl/frame_sync.sv
`timescale 1ns/10ps

module frame_sync (
    input  logic               clk_i,
    input  logic               rst_i,
    input  frame_pkg::cp_len_t cp_len_i,
    sample_if.dst              in_bus,
    sample_if.src              out_bus,
    output logic               ssb_start_o
);

    frame_pkg::frame_state_t state;
    frame_pkg::samp_cnt_t    cnt;
    frame_pkg::sym_idx_t     sym;
    frame_pkg::cp_len_t      cp_q;
    logic                    sym_end;
    logic                    cp_end;

    assign sym_end = (cnt == frame_pkg::samp_cnt_t'(frame_pkg::SYM_LEN - 1));
    // only evaluated in FS_CP, where cp_q is at least one.
    assign cp_end = (cnt == frame_pkg::samp_cnt_t'(cp_q - 4'd1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= frame_pkg::FS_IDLE;
            cnt <= '0;
            sym <= '0;
            cp_q <= '0;
            ssb_start_o <= 1'b0;
            out_bus.valid <= 1'b0;
            out_bus.symbol_start <= 1'b0;
            out_bus.last <= 1'b0;
            out_bus.symbol_idx <= '0;
        end else begin
            ssb_start_o <= 1'b0;
            out_bus.valid <= 1'b0;
            out_bus.symbol_start <= 1'b0;
            out_bus.last <= 1'b0;
            if (in_bus.valid) begin
                case (state)
                    frame_pkg::FS_IDLE: begin
                        if (in_bus.peak) begin
                            // the prefix length is sampled once per block.
                            cp_q <= cp_len_i;
                            cnt <= '0;
                            sym <= '0;
                            ssb_start_o <= 1'b1;
                            state <= (cp_len_i == '0) ? frame_pkg::FS_SYMBOL : frame_pkg::FS_CP;
                        end
                    end
                    frame_pkg::FS_CP: begin
                        if (cp_end) begin
                            cnt <= '0;
                            state <= frame_pkg::FS_SYMBOL;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    frame_pkg::FS_SYMBOL: begin
                        out_bus.valid <= 1'b1;
                        out_bus.symbol_start <= (cnt == '0);
                        out_bus.last <= sym_end;
                        out_bus.symbol_idx <= sym;
                        if (sym_end) begin
                            cnt <= '0;
                            if (sym == frame_pkg::sym_idx_t'(frame_pkg::SSB_SYMBOLS - 1)) begin
                                state <= frame_pkg::FS_IDLE;
                            end else begin
                                sym <= sym + 1'b1;
                                state <= (cp_q == '0) ? frame_pkg::FS_SYMBOL : frame_pkg::FS_CP;
                            end
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: state <= frame_pkg::FS_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_bus.valid) begin
            out_bus.data <= in_bus.data;
        end
    end

    assign out_bus.metric = '0;
    assign out_bus.peak = 1'b0;

endmodule

//--- hdl/sync_config.sv
`timescale 1ns/10ps

module sync_config (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 cfg_we_i,
    input  frame_pkg::cfg_addr_t cfg_addr_i,
    input  logic [15:0]          cfg_wdata_i,
    output logic [15:0]          cfg_rdata_o,
    input  logic                 ssb_start_i,
    output sync_pkg::metric_t    thresh_o,
    output frame_pkg::cp_len_t   cp_len_o
);

    logic [15:0] ssb_count;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            thresh_o <= sync_pkg::metric_t'(frame_pkg::RST_THRESH);
            cp_len_o <= frame_pkg::RST_CP_LEN;
            ssb_count <= '0;
        end else begin
            if (cfg_we_i && cfg_addr_i == frame_pkg::CFG_THRESH) begin
                thresh_o <= sync_pkg::metric_t'(cfg_wdata_i);
            end
            if (cfg_we_i && cfg_addr_i == frame_pkg::CFG_CP_LEN) begin
                cp_len_o <= frame_pkg::cp_len_t'(cfg_wdata_i);
            end
            // the counter adds one per started block and wraps.
            if (ssb_start_i) begin
                ssb_count <= ssb_count + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            frame_pkg::CFG_THRESH:    cfg_rdata_o = 16'(thresh_o);
            frame_pkg::CFG_CP_LEN:    cfg_rdata_o = 16'(cp_len_o);
            frame_pkg::CFG_SSB_COUNT: cfg_rdata_o = ssb_count;
            default:                  cfg_rdata_o = '0;
        endcase
    end

endmodule

//--- hdl/ssb_sync_top.sv
`timescale 1ns/10ps

module ssb_sync_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  sync_pkg::iq_t        s_data_i,
    input  logic                 s_valid_i,
    output sync_pkg::iq_t        m_data_o,
    output logic                 m_valid_o,
    output logic                 m_symbol_start_o,
    output logic                 m_last_o,
    output frame_pkg::sym_idx_t  m_symbol_idx_o,
    output logic                 peak_o,
    input  logic                 cfg_we_i,
    input  frame_pkg::cfg_addr_t cfg_addr_i,
    input  logic [15:0]          cfg_wdata_i,
    output logic [15:0]          cfg_rdata_o
);

    sample_if corr_bus ();
    sample_if det_bus ();
    sample_if frame_bus ();

    sync_pkg::metric_t  thresh;
    frame_pkg::cp_len_t cp_len;
    logic               ssb_start;

    pss_correlator u_corr (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .s_data_i  (s_data_i),
        .s_valid_i (s_valid_i),
        .out_bus   (corr_bus.src)
    );

    peak_detector u_peak (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .thresh_i (thresh),
        .in_bus   (corr_bus.dst),
        .out_bus  (det_bus.src)
    );

    frame_sync u_frame (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cp_len_i    (cp_len),
        .in_bus      (det_bus.dst),
        .out_bus     (frame_bus.src),
        .ssb_start_o (ssb_start)
    );

    sync_config u_cfg (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .ssb_start_i (ssb_start),
        .thresh_o    (thresh),
        .cp_len_o    (cp_len)
    );

    // peak_o follows every detected peak even inside a block.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            peak_o <= 1'b0;
        end else begin
            peak_o <= det_bus.peak;
        end
    end

    assign m_data_o = frame_bus.data;
    assign m_valid_o = frame_bus.valid;
    assign m_symbol_start_o = frame_bus.symbol_start;
    assign m_last_o = frame_bus.last;
    assign m_symbol_idx_o = frame_bus.symbol_idx;

endmodule

//--- verif/tb_ssb_sync_top.sv
`timescale 1ns/10ps

module tb_ssb_sync_top;

    localparam int BURSTS = 6;
    localparam int RUNS = 4;
    localparam int BURST_SAMPLES = 350;
    localparam int STIM_CYCLES = RUNS * BURSTS * BURST_SAMPLES * 4 / 3 + 600;
    localparam int TIMEOUT_CYCLES = 8 * STIM_CYCLES;

    logic                 clk_i;
    logic                 rst_i;
    sync_pkg::iq_t        s_data_i;
    logic                 s_valid_i;
    sync_pkg::iq_t        m_data_o;
    logic                 m_valid_o;
    logic                 m_symbol_start_o;
    logic                 m_last_o;
    frame_pkg::sym_idx_t  m_symbol_idx_o;
    logic                 peak_o;
    logic                 cfg_we_i;
    frame_pkg::cfg_addr_t cfg_addr_i;
    logic [15:0]          cfg_wdata_i;
    logic [15:0]          cfg_rdata_o;

    logic [31:0] rng_state = 32'h560e_1a98;
    int          cycle_cnt = 0;
    int          peak_seen = 0;
    logic [19:0] exp_word;

    // the model window holds signed I and Q with index 0 as the oldest sample.
    int                      win_i [sync_pkg::PSS_LEN];
    int                      win_q [sync_pkg::PSS_LEN];
    int                      n_seen = 0;
    logic                    have_held = 1'b0;
    sync_pkg::iq_t           held_iq;
    int                      held_m = 0;
    int                      prev_m = 0;
    int                      model_thresh = frame_pkg::RST_THRESH;
    int                      model_cp = frame_pkg::RST_CP_LEN;
    frame_pkg::frame_state_t fs = frame_pkg::FS_IDLE;
    int                      f_cnt = 0;
    int                      f_sym = 0;
    int                      f_cp = 0;
    int                      model_blocks = 0;
    int                      model_peaks = 0;
    // each entry is {data, symbol_start, last, symbol_idx}.
    logic [19:0]             exp_q [$];

    ssb_sync_top UUT (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .s_data_i         (s_data_i),
        .s_valid_i        (s_valid_i),
        .m_data_o         (m_data_o),
        .m_valid_o        (m_valid_o),
        .m_symbol_start_o (m_symbol_start_o),
        .m_last_o         (m_last_o),
        .m_symbol_idx_o   (m_symbol_idx_o),
        .peak_o           (peak_o),
        .cfg_we_i         (cfg_we_i),
        .cfg_addr_i       (cfg_addr_i),
        .cfg_wdata_i      (cfg_wdata_i),
        .cfg_rdata_o      (cfg_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic end_with_failure();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, expected);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:8]) % n;
    endfunction

    function automatic sync_pkg::iq_t make_iq(input int i, input int q);
        return {i[7:0], q[7:0]};
    endfunction

    task automatic predict_framing(input sync_pkg::iq_t iq, input logic peak);
        if (peak) begin
            model_peaks++;
        end
        case (fs)
            frame_pkg::FS_IDLE: begin
                if (peak) begin
                    model_blocks++;
                    f_cp = model_cp;
                    f_cnt = 0;
                    f_sym = 0;
                    fs = (f_cp == 0) ? frame_pkg::FS_SYMBOL : frame_pkg::FS_CP;
                end
            end
            frame_pkg::FS_CP: begin
                f_cnt++;
                if (f_cnt == f_cp) begin
                    f_cnt = 0;
                    fs = frame_pkg::FS_SYMBOL;
                end
            end
            default: begin
                exp_q.push_back({iq, f_cnt == 0, f_cnt == frame_pkg::SYM_LEN - 1, 2'(f_sym)});
                f_cnt++;
                if (f_cnt == frame_pkg::SYM_LEN) begin
                    f_cnt = 0;
                    if (f_sym == frame_pkg::SSB_SYMBOLS - 1) begin
                        fs = frame_pkg::FS_IDLE;
                    end else begin
                        f_sym++;
                        fs = (f_cp == 0) ? frame_pkg::FS_SYMBOL : frame_pkg::FS_CP;
                    end
                end
            end
        endcase
    endtask

    // a held sample is judged once the sample after it is known.
    task automatic predict_sample(input int i, input int q);
        int   sum_i;
        int   sum_q;
        int   m;
        logic peak;
        for (int k = 0; k < sync_pkg::PSS_LEN - 1; k++) begin
            win_i[k] = win_i[k + 1];
            win_q[k] = win_q[k + 1];
        end
        win_i[sync_pkg::PSS_LEN - 1] = i;
        win_q[sync_pkg::PSS_LEN - 1] = q;
        n_seen++;
        sum_i = 0;
        sum_q = 0;
        for (int k = 0; k < sync_pkg::PSS_LEN; k++) begin
            sum_i += sync_pkg::PSS_SEQ[k] ? win_i[k] : -win_i[k];
            sum_q += sync_pkg::PSS_SEQ[k] ? win_q[k] : -win_q[k];
        end
        m = (sum_i < 0 ? -sum_i : sum_i) + (sum_q < 0 ? -sum_q : sum_q);
        if (n_seen < sync_pkg::PSS_LEN) begin
            m = 0;
        end
        if (have_held) begin
            peak = (held_m >= model_thresh) && (held_m > prev_m) && (held_m >= m);
            predict_framing(held_iq, peak);
            prev_m = held_m;
        end
        held_iq = make_iq(i, q);
        held_m = m;
        have_held = 1'b1;
    endtask

    task automatic drive_cycle(input logic valid, input sync_pkg::iq_t data);
        @(posedge clk_i);
        #1;
        s_valid_i = valid;
        s_data_i = data;
    endtask

    // about one cycle in four is left idle.
    task automatic send_sample(input int i, input int q);
        while (rand_below(4) == 0) begin
            drive_cycle(1'b0, '0);
        end
        drive_cycle(1'b1, make_iq(i, q));
        predict_sample(i, q);
    endtask

    task automatic send_noise(input int n);
        repeat (n) send_sample(rand_below(9) - 4, rand_below(9) - 4);
    endtask

    task automatic send_pss();
        int amp;
        int s;
        amp = 12 + rand_below(16);
        for (int k = 0; k < sync_pkg::PSS_LEN; k++) begin
            s = sync_pkg::PSS_SEQ[k] ? amp : -amp;
            send_sample(s + rand_below(5) - 2, -s / 2 + rand_below(5) - 2);
        end
    endtask

    // every second burst carries a repeat PSS that lands inside the block.
    task automatic run_bursts(input int n);
        for (int b = 0; b < n; b++) begin
            send_noise(20 + rand_below(44));
            send_pss();
            if (b % 2 == 1) begin
                send_noise(30);
                send_pss();
            end
            send_noise(220);
        end
        repeat (10) drive_cycle(1'b0, '0);
    endtask

    task automatic write_reg(input frame_pkg::cfg_addr_t addr, input int value);
        @(posedge clk_i);
        #1;
        cfg_we_i = 1'b1;
        cfg_addr_i = addr;
        cfg_wdata_i = 16'(value);
        @(posedge clk_i);
        #1;
        cfg_we_i = 1'b0;
        if (addr == frame_pkg::CFG_THRESH) begin
            model_thresh = value;
        end else if (addr == frame_pkg::CFG_CP_LEN) begin
            model_cp = value;
        end
    endtask

    task automatic read_reg(input frame_pkg::cfg_addr_t addr, output int value);
        @(posedge clk_i);
        #1;
        cfg_addr_i = addr;
        @(negedge clk_i);
        value = int'(cfg_rdata_o);
    endtask

    task automatic check_counts();
        int count;
        check_value(exp_q.size(), 0, "expected samples still pending");
        read_reg(frame_pkg::CFG_SSB_COUNT, count);
        check_value(count, model_blocks, "block count");
        check_value(peak_seen, model_peaks, "peak_o pulse count");
    endtask

    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (peak_o) begin
                peak_seen++;
            end
            if (m_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("DUT produced a framed sample the model did not expect at %0t",
                             $time);
                    end_with_failure();
                end else begin
                    exp_word = exp_q.pop_front();
                    check_value(int'(m_data_o), int'(exp_word[19:4]), "m_data_o");
                    check_value(int'(m_symbol_start_o), int'(exp_word[3]), "m_symbol_start_o");
                    check_value(int'(m_last_o), int'(exp_word[2]), "m_last_o");
                    check_value(int'(m_symbol_idx_o), int'(exp_word[1:0]), "m_symbol_idx_o");
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    initial begin
        int value;
        int count_before;
        rst_i = 1'b1;
        s_valid_i = 1'b0;
        s_data_i = '0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_value(int'({m_valid_o, m_symbol_start_o, m_last_o, peak_o}), 0,
                    "outputs after reset");

        read_reg(frame_pkg::CFG_THRESH, value);
        check_value(value, frame_pkg::RST_THRESH, "threshold reset value");
        read_reg(frame_pkg::CFG_CP_LEN, value);
        check_value(value, int'(frame_pkg::RST_CP_LEN), "prefix reset value");
        read_reg(frame_pkg::CFG_SSB_COUNT, value);
        check_value(value, 0, "block count reset value");
        write_reg(frame_pkg::CFG_THRESH, 300);
        write_reg(frame_pkg::CFG_CP_LEN, 9);
        read_reg(frame_pkg::CFG_THRESH, value);
        check_value(value, 300, "threshold readback");
        read_reg(frame_pkg::CFG_CP_LEN, value);
        check_value(value, 9, "prefix readback");

        write_reg(frame_pkg::CFG_CP_LEN, 4);
        run_bursts(BURSTS);
        check_counts();

        write_reg(frame_pkg::CFG_CP_LEN, 7);
        run_bursts(BURSTS);
        check_counts();

        // no model metric can reach the largest threshold.
        write_reg(frame_pkg::CFG_THRESH, 16383);
        read_reg(frame_pkg::CFG_SSB_COUNT, count_before);
        run_bursts(BURSTS);
        read_reg(frame_pkg::CFG_SSB_COUNT, value);
        check_value(value, count_before, "block count under a high threshold");
        check_counts();

        write_reg(frame_pkg::CFG_THRESH, 300);
        run_bursts(BURSTS);
        check_counts();

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- ssb_sync_top.f
hdl/sync_pkg.sv
hdl/frame_pkg.sv
hdl/sample_if.sv
hdl/pss_correlator.sv
hdl/peak_detector.sv
hdl/frame_sync.sv
hdl/sync_config.sv
hdl/ssb_sync_top.sv
verif/tb_ssb_sync_top.sv

//--- Makefile
SRCS := $(shell cat ssb_sync_top.f)

obj_dir/Vtb_ssb_sync_top: ssb_sync_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f ssb_sync_top.f --top-module tb_ssb_sync_top

.PHONY: run clean

run: obj_dir/Vtb_ssb_sync_top
	@out="$$(./obj_dir/Vtb_ssb_sync_top)"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
